/* rtl/codeLockPkg.sv */
`default_nettype none

package codeLockPkg;

	typedef logic [3:0] digitT;

	// index 0 holds the newest key
	typedef digitT [2:0] codeT;

	typedef enum logic [1:0]
	{
		vIdle,
		vFail,
		vPass,
		vLocked
	} verdictT;

	typedef struct packed
	{
		codeT code;
		verdictT verdict;
		logic [3:0] tries;
	} lockStatusT;

	localparam int MAX_TRIES = 6; // failures before lockout
	localparam int SCAN_DIV_BITS = 16; // 2^16 cycles per digit

	localparam logic [7:0] SEG_P = 8'h73;
	localparam logic [7:0] SEG_DASH = 8'h40; // segment g only
	localparam logic [7:0] SEG_BLANK = 8'h00;

	// common seven-segment map, bit 0 is segment a
	function automatic logic [7:0] segOf(input digitT d);
		logic [7:0] pattern;
		case (d)
			4'd0: pattern = 8'h3F;
			4'd1: pattern = 8'h06;
			4'd2: pattern = 8'h5B;
			4'd3: pattern = 8'h4F;
			4'd4: pattern = 8'h66;
			4'd5: pattern = 8'h6D;
			4'd6: pattern = 8'h7D;
			4'd7: pattern = 8'h07;
			4'd8: pattern = 8'h7F;
			4'd9: pattern = 8'h6F;
			default: pattern = SEG_BLANK; // not a BCD digit
		endcase
		return pattern;
	endfunction

endpackage

`default_nettype wire

/* rtl/digitEntry.sv */
`timescale 1ns/10ps
`default_nettype none

module digitEntry
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic keyValid,
	input wire codeLockPkg::digitT keyDigit,
	input wire logic enterKey,
	input wire logic clearKey,
	input wire logic locked,
	output codeLockPkg::codeT code,
	output logic submit
);

	logic keyOk;
	logic acceptKeys;
	codeLockPkg::codeT codeNext;
	logic submitNext;

	assign keyOk = keyValid && (keyDigit <= 4'd9); // drop non-BCD keys
	assign acceptKeys = !locked;

	// clear beats enter, enter beats a digit
	always_comb
	begin
		codeNext = code;
		submitNext = 1'b0;
		if (acceptKeys)
		begin
			if (clearKey)
			begin
				codeNext = '0;
			end
			else if (enterKey)
			begin
				submitNext = 1'b1; // code held while judged
			end
			else if (keyOk)
			begin
				codeNext[2] = code[1]; // oldest digit falls out
				codeNext[1] = code[0];
				codeNext[0] = keyDigit;
			end
		end
	end

	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			code <= '0;
		end
		else
		begin
			code <= codeNext;
		end
	end

	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			submit <= 1'b0;
		end
		else
		begin
			submit <= submitNext; // one-cycle pulse
		end
	end

endmodule

`default_nettype wire

/* rtl/codeJudge.sv */
`timescale 1ns/10ps
`default_nettype none

module codeJudge
(
	input wire logic CLK,
	input wire logic arstN,
	input wire codeLockPkg::codeT code,
	input wire logic submit,
	input wire codeLockPkg::codeT secret,
	output codeLockPkg::lockStatusT status,
	output logic locked,
	output logic unlocked
);

	codeLockPkg::codeT codeQ;
	codeLockPkg::verdictT verdict;
	codeLockPkg::verdictT verdictNext;
	logic [3:0] tries;
	logic [3:0] triesNext;
	logic [3:0] triesInc;
	logic unlockedNext;
	logic match;
	logic codeChanged;
	logic lockHit;

	assign match = (code == secret);
	assign codeChanged = (code != codeQ); // compared with last cycle's code
	assign triesInc = tries + 4'd1;
	assign lockHit = (triesInc == 4'(codeLockPkg::MAX_TRIES));

	always_comb
	begin
		verdictNext = verdict;
		triesNext = tries;
		unlockedNext = unlocked;
		if (verdict == codeLockPkg::vLocked)
		begin
			unlockedNext = 1'b0; // only reset gets out of here
		end
		else if (submit)
		begin
			if (match)
			begin
				verdictNext = codeLockPkg::vPass;
				unlockedNext = 1'b1;
			end
			else
			begin
				triesNext = triesInc;
				unlockedNext = 1'b0;
				if (lockHit)
				begin
					verdictNext = codeLockPkg::vLocked;
				end
				else
				begin
					verdictNext = codeLockPkg::vFail;
				end
			end
		end
		else if ((verdict == codeLockPkg::vPass) && codeChanged)
		begin
			verdictNext = codeLockPkg::vIdle; // new typing closes the lock
			unlockedNext = 1'b0;
		end
	end

	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			verdict <= codeLockPkg::vIdle;
			tries <= '0;
			unlocked <= 1'b0;
		end
		else
		begin
			verdict <= verdictNext;
			tries <= triesNext;
			unlocked <= unlockedNext;
		end
	end

	// follows the entry stage one cycle later
	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			codeQ <= '0;
		end
		else
		begin
			codeQ <= code;
		end
	end

	assign status.code = codeQ;
	assign status.verdict = verdict;
	assign status.tries = tries;
	assign locked = (verdict == codeLockPkg::vLocked);

endmodule

`default_nettype wire

/* rtl/scanDisplay.sv */
`timescale 1ns/10ps
`default_nettype none

module scanDisplay
#(
	parameter int scanDivBits = 16
)
(
	input wire logic CLK,
	input wire logic arstN,
	input wire codeLockPkg::lockStatusT status,
	output logic [7:0] segments,
	output logic [3:0] anodes
);

	localparam int CNT_BITS = scanDivBits + 2;

	logic [CNT_BITS-1:0] scanCnt;
	logic [1:0] slot;
	codeLockPkg::digitT slotDigit;
	logic [7:0] digitSeg;
	logic [7:0] statusSeg;

	// free running, top two bits pick the digit
	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			scanCnt <= '0;
		end
		else
		begin
			scanCnt <= scanCnt + 1'b1;
		end
	end

	assign slot = scanCnt[CNT_BITS-1 -: 2];

	// common anode, low enables the digit
	always_comb
	begin
		case (slot)
			2'd0: anodes = 4'b1110;
			2'd1: anodes = 4'b1101;
			2'd2: anodes = 4'b1011;
			default: anodes = 4'b0111;
		endcase
	end

	always_comb
	begin
		case (slot)
			2'd0: slotDigit = status.code[0]; // newest key on the right
			2'd1: slotDigit = status.code[1];
			2'd2: slotDigit = status.code[2];
			default: slotDigit = status.tries;
		endcase
	end

	assign digitSeg = codeLockPkg::segOf(slotDigit);

	// status digit overrides the try count
	always_comb
	begin
		case (status.verdict)
			codeLockPkg::vPass: statusSeg = codeLockPkg::SEG_P;
			codeLockPkg::vLocked: statusSeg = codeLockPkg::SEG_DASH;
			default: statusSeg = digitSeg;
		endcase
	end

	always_comb
	begin
		if (slot == 2'd3)
		begin
			segments = statusSeg;
		end
		else
		begin
			segments = digitSeg;
		end
	end

endmodule

`default_nettype wire

/* rtl/codeLock.sv */
`timescale 1ns/10ps
`default_nettype none

module codeLock
#(
	parameter int scanDivBits = codeLockPkg::SCAN_DIV_BITS
)
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic keyValid,
	input wire codeLockPkg::digitT keyDigit,
	input wire logic enterKey,
	input wire logic clearKey,
	input wire codeLockPkg::codeT secret,
	output logic [7:0] segments,
	output logic [3:0] anodes,
	output logic unlocked
);

	codeLockPkg::codeT code;
	logic submit;
	logic locked; // feeds back to block the keypad
	codeLockPkg::lockStatusT status;

	digitEntry entry0
	(
		.CLK(CLK),
		.arstN(arstN),
		.keyValid(keyValid),
		.keyDigit(keyDigit),
		.enterKey(enterKey),
		.clearKey(clearKey),
		.locked(locked),
		.code(code),
		.submit(submit)
	);

	codeJudge judge0
	(
		.CLK(CLK),
		.arstN(arstN),
		.code(code),
		.submit(submit),
		.secret(secret),
		.status(status),
		.locked(locked),
		.unlocked(unlocked)
	);

	scanDisplay #(.scanDivBits(scanDivBits)) display0
	(
		.CLK(CLK),
		.arstN(arstN),
		.status(status),
		.segments(segments),
		.anodes(anodes)
	);

endmodule

`default_nettype wire

/* dv/codeLockTb.sv */
`timescale 1ns/10ps
`default_nettype none

module codeLockTb;

	localparam int SCAN_BITS = 2;
	localparam int SCAN_LEN = 4 << SCAN_BITS; // one full rotation
	localparam int SCAN_LIMIT = 2 * SCAN_LEN;

	logic CLK;
	logic arstN;
	logic keyValid;
	codeLockPkg::digitT keyDigit;
	logic enterKey;
	logic clearKey;
	codeLockPkg::codeT secret;
	logic [7:0] segments;
	logic [3:0] anodes;
	logic unlocked;

	codeLockPkg::codeT mCode; // reference model state
	codeLockPkg::verdictT mVerdict;
	logic [3:0] mTries;
	logic [SCAN_BITS+1:0] scanRef;

	int errCount;
	int failCount;
	int guard;

	codeLock #(.scanDivBits(SCAN_BITS)) dut0
	(
		.CLK(CLK),
		.arstN(arstN),
		.keyValid(keyValid),
		.keyDigit(keyDigit),
		.enterKey(enterKey),
		.clearKey(clearKey),
		.secret(secret),
		.segments(segments),
		.anodes(anodes),
		.unlocked(unlocked)
	);

	always #50 CLK = ~CLK;

	// expected scan position
	always @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			scanRef <= '0;
		end
		else
		begin
			scanRef <= scanRef + 1'b1;
		end
	end

	task automatic checkSeg(input logic [7:0] got, input logic [7:0] exp, input string name);
		if (got !== exp)
		begin
			errCount = errCount + 1;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkAnodes(input logic [3:0] got, input logic [3:0] exp, input string name);
		if (got !== exp)
		begin
			errCount = errCount + 1;
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string name);
		if (got !== exp)
		begin
			errCount = errCount + 1;
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	function automatic codeLockPkg::codeT randomCode();
		codeLockPkg::codeT c;
		c[0] = 4'($urandom_range(9, 0));
		c[1] = 4'($urandom_range(9, 0));
		c[2] = 4'($urandom_range(9, 0));
		return c;
	endfunction

	function automatic logic [7:0] expectedSeg(input logic [1:0] slot);
		logic [7:0] seg;
		if (slot != 2'd3)
		begin
			seg = codeLockPkg::segOf(mCode[slot]);
		end
		else if (mVerdict == codeLockPkg::vPass)
		begin
			seg = codeLockPkg::SEG_P;
		end
		else if (mVerdict == codeLockPkg::vLocked)
		begin
			seg = codeLockPkg::SEG_DASH;
		end
		else
		begin
			seg = codeLockPkg::segOf(mTries); // try count digit
		end
		return seg;
	endfunction

	// clear wins over enter and enter over a digit
	task automatic modelStep(input logic kv, input codeLockPkg::digitT kd, input logic ent,
		input logic clr);
		codeLockPkg::codeT nextCode;
		nextCode = mCode;
		if (mVerdict != codeLockPkg::vLocked)
		begin
			if (clr)
			begin
				nextCode = '0;
			end
			else if (ent)
			begin
				if (mCode == secret)
				begin
					mVerdict = codeLockPkg::vPass;
				end
				else
				begin
					mTries = mTries + 4'd1;
					if (mTries == codeLockPkg::MAX_TRIES)
					begin
						mVerdict = codeLockPkg::vLocked;
					end
					else
					begin
						mVerdict = codeLockPkg::vFail;
					end
				end
			end
			else if (kv && (kd <= 4'd9))
			begin
				nextCode[2] = mCode[1];
				nextCode[1] = mCode[0];
				nextCode[0] = kd;
			end
			if ((mVerdict == codeLockPkg::vPass) && (nextCode != mCode))
			begin
				mVerdict = codeLockPkg::vIdle; // only a real change closes it
			end
			mCode = nextCode;
		end
	endtask

	// every slot of one rotation against the model
	task automatic watchScan();
		logic [3:0] seen;
		logic [3:0] expAnodes;
		logic [1:0] slot;
		int cycles;
		seen = '0;
		cycles = 0;
		while (((cycles < SCAN_LEN) || (seen != 4'hF)) && (cycles < SCAN_LIMIT))
		begin
			@(negedge CLK);
			slot = scanRef[SCAN_BITS+1 -: 2];
			expAnodes = ~(4'b0001 << slot);
			checkAnodes(anodes, expAnodes, "anodes");
			checkSeg(segments, expectedSeg(slot), "segments");
			checkBit(unlocked, (mVerdict == codeLockPkg::vPass), "unlocked");
			case (anodes)
				4'b1110: seen[0] = 1'b1;
				4'b1101: seen[1] = 1'b1;
				4'b1011: seen[2] = 1'b1;
				4'b0111: seen[3] = 1'b1;
				default: ;
			endcase
			cycles = cycles + 1;
		end
		if (seen != 4'hF)
		begin
			failCount = failCount + 1;
			$display("the display did not visit all four digits within %0d cycles (time %0t)",
				SCAN_LIMIT, $time);
		end
	endtask

	task automatic stroke(input logic kv, input codeLockPkg::digitT kd, input logic ent,
		input logic clr);
		@(negedge CLK);
		keyValid = kv;
		keyDigit = kd;
		enterKey = ent;
		clearKey = clr;
		@(negedge CLK);
		keyValid = 1'b0;
		enterKey = 1'b0;
		clearKey = 1'b0;
		modelStep(kv, kd, ent, clr);
		repeat (3) @(negedge CLK); // let the pipeline settle
		watchScan();
	endtask

	task automatic typeCode(input codeLockPkg::codeT c);
		stroke(1'b1, c[2], 1'b0, 1'b0);
		stroke(1'b1, c[1], 1'b0, 1'b0);
		stroke(1'b1, c[0], 1'b0, 1'b0);
	endtask

	task automatic enterWrong();
		codeLockPkg::codeT c;
		c = randomCode();
		if (c == secret)
		begin
			c[0] = (c[0] == 4'd9) ? 4'd0 : c[0] + 4'd1;
		end
		typeCode(c);
		stroke(1'b0, 4'd0, 1'b1, 1'b0);
	endtask

	task automatic enterRight();
		typeCode(secret);
		stroke(1'b0, 4'd0, 1'b1, 1'b0);
	endtask

	task automatic setSecret(input codeLockPkg::codeT c);
		@(negedge CLK);
		secret = c;
	endtask

	task automatic resetDut();
		@(negedge CLK);
		arstN = 1'b0;
		keyValid = 1'b0;
		enterKey = 1'b0;
		clearKey = 1'b0;
		mCode = '0;
		mVerdict = codeLockPkg::vIdle;
		mTries = '0;
		repeat (2) @(negedge CLK);
		arstN = 1'b1;
	endtask

	task automatic randomMix(input int count);
		int pick;
		logic kv;
		logic ent;
		logic clr;
		for (int i = 0; i < count; i++)
		begin
			pick = $urandom_range(9, 0);
			kv = 1'($urandom_range(1, 0));
			ent = 1'($urandom_range(1, 0));
			clr = 1'($urandom_range(1, 0));
			case (pick)
				0, 1, 2, 3: stroke(1'b1, 4'($urandom_range(9, 0)), 1'b0, 1'b0);
				4: stroke(1'b1, 4'(10 + $urandom_range(5, 0)), 1'b0, 1'b0); // not BCD
				5: stroke(1'b0, 4'd0, 1'b0, 1'b1);
				6: stroke(1'b0, 4'd0, 1'b1, 1'b0);
				7: stroke(kv, 4'($urandom_range(15, 0)), ent, clr); // strobes together
				8: setSecret(randomCode());
				default: enterRight();
			endcase
		end
	endtask

	initial
	begin
		#2_000_000;
		$display("simulation ran past its time limit");
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hec36_a1fb));
		CLK = 1'b0;
		arstN = 1'b1;
		keyValid = 1'b0;
		keyDigit = '0;
		enterKey = 1'b0;
		clearKey = 1'b0;
		secret = '0;
		errCount = 0;
		failCount = 0;

		resetDut();
		watchScan();

		repeat (12)
		begin
			stroke(1'b1, 4'($urandom_range(9, 0)), 1'b0, 1'b0);
		end
		stroke(1'b1, 4'(10 + $urandom_range(5, 0)), 1'b0, 1'b0);
		stroke(1'b1, 4'd15, 1'b0, 1'b0);
		stroke(1'b0, 4'd0, 1'b0, 1'b1);

		setSecret(randomCode());
		repeat (3) enterWrong();

		enterRight();
		stroke(1'b1, 4'($urandom_range(9, 0)), 1'b0, 1'b0);
		enterRight();
		stroke(1'b0, 4'd0, 1'b0, 1'b1);

		randomMix(40);

		// drive into lockout
		guard = 0;
		while ((mVerdict != codeLockPkg::vLocked) && (guard < 2 * codeLockPkg::MAX_TRIES))
		begin
			enterWrong();
			guard = guard + 1;
		end

		stroke(1'b1, 4'($urandom_range(9, 0)), 1'b0, 1'b0);
		stroke(1'b0, 4'd0, 1'b0, 1'b1);
		enterRight();
		stroke(1'b1, 4'd3, 1'b1, 1'b1);

		resetDut();
		watchScan();
		enterRight();

		$display("mismatches: %0d, other failures: %0d", errCount, failCount);
		if ((errCount == 0) && (failCount == 0))
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* codeLock.f */
rtl/codeLockPkg.sv
rtl/digitEntry.sv
rtl/codeJudge.sv
rtl/scanDisplay.sv
rtl/codeLock.sv
dv/codeLockTb.sv

/* Bender.yml */
package:
  name: codeLock

sources:
  - files:
      - rtl/codeLockPkg.sv
      - rtl/digitEntry.sv
      - rtl/codeJudge.sv
      - rtl/scanDisplay.sv
      - rtl/codeLock.sv
  - target: test
    files:
      - dv/codeLockTb.sv
